/* logic/pm_config.svh */
`ifndef PM_CONFIG_SVH
`define PM_CONFIG_SVH

////////////////////////////////////////////////////////////
// Program memory geometry
////////////////////////////////////////////////////////////

// Words in the program memory, kept small for quick runs
`define PM_DEPTH 64

// Address width, log2 of PM_DEPTH
`define PM_AW 6

// Instruction word width
`define PM_DW 32

// Width of the loader word counter, one extra bit to hold PM_DEPTH
`define PM_CW (`PM_AW + 1)

`endif

/* logic/pm_pkg.sv */
`default_nettype none

`include "pm_config.svh"

package pm_pkg;

  ////////////////////////////////////////////////////////////
  // Memory port request
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              req;    // Request strobe this cycle
    logic              we;     // 1 write, 0 read
    logic [`PM_AW-1:0] addr;   // Word address
    logic [`PM_DW-1:0] wdata;  // Write data, don't care on reads
  } pm_req_t;

  // Idle port, nothing requested
  localparam pm_req_t PM_REQ_IDLE = '0;

  ////////////////////////////////////////////////////////////
  // Fetched instruction
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`PM_AW-1:0] pc;     // Address the word was read from
    logic [`PM_DW-1:0] instr;  // Instruction word
  } fetch_word_t;

endpackage

`default_nettype wire

/* logic/program_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module program_memory import pm_pkg::*; (
  input  wire logic              i_clk,
  input  wire logic              i_rsta,
  input  wire logic              i_clear,     // One-cycle pulse, starts the sweep
  input  wire pm_req_t           i_req,       // Single port request
  output logic [`PM_DW-1:0]      o_rdata,     // Second read stage
  output logic                   o_busy,      // Sweep in progress
  output logic                   o_overwrite  // Sticky, write hit a non-zero word
);

  localparam logic [`PM_AW-1:0] LAST_ADDR = `PM_AW'(`PM_DEPTH - 1);

  logic [`PM_DW-1:0] mem [`PM_DEPTH];  // Program storage
  logic [`PM_DW-1:0] rd_q;             // First read stage
  logic [`PM_AW-1:0] sweep_cnt;        // Address being zeroed
  logic              sweep_done;       // Last word of the sweep this cycle
  logic              wr_go;            // Accepted write
  logic              rd_go;            // Accepted read

  // Port is closed to requests while the sweep runs
  assign wr_go      = i_req.req &&  i_req.we && !o_busy;
  assign rd_go      = i_req.req && !i_req.we && !o_busy;
  assign sweep_done = o_busy && (sweep_cnt == LAST_ADDR);

  ////////////////////////////////////////////////////////////
  // Array write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (o_busy) begin
      mem[sweep_cnt] <= '0;             // Sweep owns the port
    end else if (wr_go) begin
      mem[i_req.addr] <= i_req.wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path, two stages
  ////////////////////////////////////////////////////////////

  // No-change mode: this stage only loads on reads
  always_ff @(posedge i_clk) begin
    if (rd_go) begin
      rd_q <= mem[i_req.addr];
    end
  end

  // Output register, cleared by reset like a BRAM output latch
  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      o_rdata <= '0;
    end else begin
      o_rdata <= rd_q;                  // Holds while rd_q holds
    end
  end

  ////////////////////////////////////////////////////////////
  // Clear sweep and overwrite flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      o_busy    <= 1'b0;
      sweep_cnt <= '0;
    end else if (i_clear) begin
      o_busy    <= 1'b1;                // Busy from the next cycle on
      sweep_cnt <= '0;                  // Always starts at word 0
    end else if (o_busy) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_done) begin
        o_busy <= 1'b0;                 // PM_DEPTH cycles, every word covered
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      o_overwrite <= 1'b0;
    end else if (sweep_done) begin
      o_overwrite <= 1'b0;              // Memory is all zero again
    end else if (wr_go && (mem[i_req.addr] != '0)) begin
      o_overwrite <= 1'b1;              // Old contents were live
    end
  end

  // Arbiter must keep the port quiet for the whole sweep
  a_no_req_while_busy: assert property (
    @(posedge i_clk) disable iff (i_rsta) o_busy |-> !i_req.req
  );

endmodule

`default_nettype wire

/* logic/memory_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module memory_arbiter import pm_pkg::*; (
  input  wire logic              i_clk,
  input  wire logic              i_rsta,
  input  wire pm_req_t           i_load_req,      // Loader write requests
  input  wire pm_req_t           i_fetch_req,     // Fetch read requests
  input  wire logic              i_busy,          // Memory sweeping
  input  wire logic [`PM_DW-1:0] i_rdata,         // Memory read data
  output pm_req_t                o_mem_req,       // Selected request
  output logic                   o_fetch_grant,   // Combinational grant level
  output logic                   o_fetch_rvalid,  // Fetch data returns now
  output logic [`PM_DW-1:0]      o_fetch_rdata
);

  logic       load_go;   // Loader forwarded this cycle
  logic [1:0] rd_fly;    // Fetch reads in flight with the older in bit 1

  ////////////////////////////////////////////////////////////
  // Fixed priority select
  ////////////////////////////////////////////////////////////

  assign load_go       = i_load_req.req && !i_busy;                    // Loader first
  assign o_fetch_grant = i_fetch_req.req && !i_busy && !i_load_req.req;

  always_comb begin
    if (load_go) begin
      o_mem_req = i_load_req;
    end else if (o_fetch_grant) begin
      o_mem_req = i_fetch_req;
    end else begin
      o_mem_req = PM_REQ_IDLE;          // Nothing goes out during a clear or an idle cycle
    end
  end

  ////////////////////////////////////////////////////////////
  // Read return tracking
  ////////////////////////////////////////////////////////////

  // Matches the two-stage memory read path
  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      rd_fly <= 2'b00;
    end else begin
      rd_fly <= {rd_fly[0], o_fetch_grant};
    end
  end

  assign o_fetch_rvalid = rd_fly[1];    // Loader writes never mark data
  assign o_fetch_rdata  = i_rdata;

  // Loader owns every forwarded write and fetch every forwarded read
  a_one_owner: assert property (
    @(posedge i_clk) disable iff (i_rsta)
      o_mem_req.req |-> (o_mem_req.we == load_go)
  );

  // Loader side only ever writes
  a_load_is_write: assert property (
    @(posedge i_clk) disable iff (i_rsta) i_load_req.req |-> i_load_req.we
  );

endmodule

`default_nettype wire

/* logic/program_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module program_loader import pm_pkg::*; (
  input  wire logic              i_clk,
  input  wire logic              i_rsta,
  input  wire logic              i_load_start,  // Restart at word 0
  input  wire logic              i_load_valid,  // One word offered
  input  wire logic [`PM_DW-1:0] i_load_word,
  input  wire logic              i_busy,        // Memory clearing, words dropped
  output pm_req_t                o_req,         // Write request to the arbiter
  output logic [`PM_CW-1:0]      o_load_count,  // Words accepted
  output logic                   o_load_full
);

  localparam logic [`PM_CW-1:0] FULL_COUNT = `PM_CW'(`PM_DEPTH);

  logic              accept;     // Word taken this cycle
  logic              req_q;      // Write strobe, one cycle after the word
  logic [`PM_AW-1:0] addr_q;     // Target address
  logic [`PM_DW-1:0] data_q;     // Target word

  assign o_load_full = (o_load_count == FULL_COUNT);
  assign accept      = i_load_valid && !o_load_full && !i_busy;

  ////////////////////////////////////////////////////////////
  // Word counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta || i_load_start) begin
      o_load_count <= '0;
    end else if (accept) begin
      o_load_count <= o_load_count + 1'b1;  // Saturates through o_load_full
    end
  end

  ////////////////////////////////////////////////////////////
  // Write request register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      req_q <= 1'b0;
    end else begin
      req_q <= accept && !i_load_start;     // Start wins over a word
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      addr_q <= o_load_count[`PM_AW-1:0];   // Next free word
      data_q <= i_load_word;
    end
  end

  assign o_req = '{req: req_q, we: 1'b1, addr: addr_q, wdata: data_q};

endmodule

`default_nettype wire

/* logic/instruction_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module instruction_fetch import pm_pkg::*; (
  input  wire logic              i_clk,
  input  wire logic              i_rsta,
  input  wire logic              i_run,          // Core running
  input  wire logic              i_grant,        // Read accepted this cycle
  input  wire logic              i_rvalid,       // Read data returns
  input  wire logic [`PM_DW-1:0] i_rdata,
  output pm_req_t                o_req,          // Read request, held until granted
  output fetch_word_t            o_instr,        // Word tagged with its address
  output logic                   o_instr_valid
);

  logic [`PM_AW-1:0] pc_q;     // Next word to read
  logic [`PM_AW-1:0] pc_d1;    // PC one cycle back
  logic [`PM_AW-1:0] pc_d2;    // PC two cycles back, lines up with i_rdata
  logic [1:0]        gnt_q;    // Own record of grants
  logic              fetch_go; // Read accepted

  assign o_req    = '{req: i_run, we: 1'b0, addr: pc_q, wdata: '0};
  assign fetch_go = o_req.req && i_grant;

  ////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      pc_q <= '0;
    end else if (!i_run) begin
      pc_q <= '0;                  // Stopped core restarts at 0
    end else if (fetch_go) begin
      pc_q <= pc_q + 1'b1;         // Wraps at PM_DEPTH
    end
  end

  ////////////////////////////////////////////////////////////
  // Latency match
  ////////////////////////////////////////////////////////////

  // Every cycle, the granted PC is picked out by i_rvalid
  always_ff @(posedge i_clk) begin
    pc_d1 <= pc_q;
    pc_d2 <= pc_d1;
  end

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      gnt_q <= 2'b00;
    end else begin
      gnt_q <= {gnt_q[0], fetch_go};
    end
  end

  // Reads in flight still come back after i_run drops
  assign o_instr       = '{pc: pc_d2, instr: i_rdata};
  assign o_instr_valid = i_rvalid;

  // Return strobe from the arbiter lines up with our own grant two cycles back
  a_rvalid_matches_grant: assert property (
    @(posedge i_clk) disable iff (i_rsta) i_rvalid == gnt_q[1]
  );

endmodule

`default_nettype wire

/* logic/program_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module program_subsystem_top import pm_pkg::*; (
  input  wire logic              i_clk,
  input  wire logic              i_rsta,
  input  wire logic              i_clear,        // Zero the whole memory
  input  wire logic              i_load_start,
  input  wire logic              i_load_valid,
  input  wire logic [`PM_DW-1:0] i_load_word,
  input  wire logic              i_run,
  output logic                   o_busy,
  output logic                   o_overwrite,
  output fetch_word_t            o_instr,
  output logic                   o_instr_valid,
  output logic [`PM_CW-1:0]      o_load_count,
  output logic                   o_load_full
);

  pm_req_t           load_req;       // Loader to arbiter
  pm_req_t           fetch_req;      // Fetch to arbiter
  pm_req_t           mem_req;        // Arbiter to memory
  logic [`PM_DW-1:0] mem_rdata;
  logic              fetch_grant;
  logic              fetch_rvalid;
  logic [`PM_DW-1:0] fetch_rdata;

  ////////////////////////////////////////////////////////////
  // Requesters
  ////////////////////////////////////////////////////////////

  program_loader program_loader_i (
    .i_clk        (i_clk),
    .i_rsta       (i_rsta),
    .i_load_start (i_load_start),
    .i_load_valid (i_load_valid),
    .i_load_word  (i_load_word),
    .i_busy       (o_busy),
    .o_req        (load_req),
    .o_load_count (o_load_count),
    .o_load_full  (o_load_full)
  );

  instruction_fetch instruction_fetch_i (
    .i_clk         (i_clk),
    .i_rsta        (i_rsta),
    .i_run         (i_run),
    .i_grant       (fetch_grant),
    .i_rvalid      (fetch_rvalid),
    .i_rdata       (fetch_rdata),
    .o_req         (fetch_req),
    .o_instr       (o_instr),
    .o_instr_valid (o_instr_valid)
  );

  ////////////////////////////////////////////////////////////
  // Shared port
  ////////////////////////////////////////////////////////////

  memory_arbiter memory_arbiter_i (
    .i_clk          (i_clk),
    .i_rsta         (i_rsta),
    .i_load_req     (load_req),
    .i_fetch_req    (fetch_req),
    .i_busy         (o_busy),
    .i_rdata        (mem_rdata),
    .o_mem_req      (mem_req),
    .o_fetch_grant  (fetch_grant),
    .o_fetch_rvalid (fetch_rvalid),
    .o_fetch_rdata  (fetch_rdata)
  );

  program_memory program_memory_i (
    .i_clk       (i_clk),
    .i_rsta      (i_rsta),
    .i_clear     (i_clear),
    .i_req       (mem_req),
    .o_rdata     (mem_rdata),
    .o_busy      (o_busy),
    .o_overwrite (o_overwrite)
  );

endmodule

`default_nettype wire

/* verif/program_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module program_subsystem_tb import pm_pkg::*; ();

  logic              i_clk = 1'b0;
  logic              i_rsta;
  logic              i_clear;
  logic              i_load_start;
  logic              i_load_valid;
  logic [`PM_DW-1:0] i_load_word;
  logic              i_run;
  logic              o_busy;
  logic              o_overwrite;
  fetch_word_t       o_instr;
  logic              o_instr_valid;
  logic [`PM_CW-1:0] o_load_count;
  logic              o_load_full;

  // Reference model
  logic [`PM_DW-1:0] model_mem [`PM_DEPTH];
  logic [`PM_AW-1:0] model_pc;
  int                model_count;
  logic              model_ovw;
  int                busy_left;          // Sweep cycles still to come
  int                busy_age;           // Cycles since o_busy rose
  logic              load_req_now;       // Loader write on the port this cycle
  logic [`PM_AW-1:0] wr_addr;
  logic [`PM_DW-1:0] wr_data;
  logic [1:0]        gnt_hist;           // Fetch grants with bit 1 two edges back
  fetch_word_t       exp_q [$];          // Reads in flight
  int                n_fetched = 0;
  logic              zero_phase;         // Memory known to be all zero
  logic [15:0]       lfsr_state = 16'd28;

  program_subsystem_top program_subsystem_top_i (
    .i_clk         (i_clk),
    .i_rsta        (i_rsta),
    .i_clear       (i_clear),
    .i_load_start  (i_load_start),
    .i_load_valid  (i_load_valid),
    .i_load_word   (i_load_word),
    .i_run         (i_run),
    .o_busy        (o_busy),
    .o_overwrite   (o_overwrite),
    .o_instr       (o_instr),
    .o_instr_valid (o_instr_valid),
    .o_load_count  (o_load_count),
    .o_load_full   (o_load_full)
  );

  always #10 i_clk = ~i_clk;             // 20 ns period

  // Taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "Wait loop ran out of cycles");
  endtask

  ////////////////////////////////////////////////////////////
  // Model steps on the falling edge where all is settled
  ////////////////////////////////////////////////////////////

  always @(negedge i_clk) begin : model_step
    fetch_word_t want;
    logic        busy_now;
    logic        grant;
    int          a;
    busy_now = (busy_left > 0);
    grant    = i_run && !busy_now && !load_req_now;  // Loader write blocks fetch
    if (i_rsta) begin
      model_pc     = '0;
      model_count  = 0;
      model_ovw    = 1'b0;
      busy_left    = 0;
      busy_age     = 0;
      load_req_now = 1'b0;
      gnt_hist     = 2'b00;
      exp_q.delete();
    end else begin
      assert (o_busy == busy_now)
        else report_error($sformatf("o_busy %0b, expected %0b", o_busy, busy_now));
      assert (o_overwrite == model_ovw)
        else report_error($sformatf("o_overwrite %0b, expected %0b", o_overwrite, model_ovw));
      assert (o_load_count == model_count && o_load_full == (model_count == `PM_DEPTH))
        else report_error($sformatf("load count %0d full %0b, expected %0d",
                                    o_load_count, o_load_full, model_count));
      assert (!(o_busy && busy_age >= 2 && o_instr_valid))
        else report_error("instruction valid in the middle of a clear");
      assert (o_instr_valid == gnt_hist[1])
        else report_error($sformatf("o_instr_valid %0b, expected %0b", o_instr_valid,
                                    gnt_hist[1]));
      if (o_instr_valid) begin
        assert (exp_q.size() > 0) else report_error("instruction with no read in flight");
        want = exp_q.pop_front();
        assert (o_instr.pc == want.pc)
          else report_error($sformatf("pc %0d, expected %0d", o_instr.pc, want.pc));
        assert (!zero_phase || o_instr.instr == '0)
          else report_error($sformatf("instr %h after clear", o_instr.instr));
        assert (o_instr.instr == want.instr)
          else report_error($sformatf("instr %h at pc %0d, expected %h",
                                      o_instr.instr, want.pc, want.instr));
        n_fetched++;
      end
      // Fetch read at the next edge sees the array before any write
      gnt_hist = {gnt_hist[0], grant};
      if (grant) begin
        want.pc    = model_pc;
        want.instr = model_mem[model_pc];
        exp_q.push_back(want);
        model_pc = model_pc + 1'b1;                    // Wraps at PM_DEPTH
      end
      if (!i_run) begin
        model_pc = '0;
      end
      if (load_req_now && !busy_now) begin
        if (model_mem[wr_addr] != '0) begin
          model_ovw = 1'b1;                            // Live word overwritten
        end
        model_mem[wr_addr] = wr_data;
      end
      load_req_now = 1'b0;
      if (i_load_start) begin
        model_count = 0;
      end else if (i_load_valid && !busy_now && model_count < `PM_DEPTH) begin
        wr_addr      = `PM_AW'(model_count);
        wr_data      = i_load_word;
        load_req_now = 1'b1;                           // Reaches the port a cycle later
        model_count++;
      end
      if (i_clear) begin
        busy_left = `PM_DEPTH;
        for (a = 0; a < `PM_DEPTH; a++) begin
          model_mem[a] = '0;                           // No read can see the partial sweep
        end
      end else if (busy_now) begin
        busy_left--;
        if (busy_left == 0) begin
          model_ovw = 1'b0;
        end
      end
      busy_age = busy_now ? busy_age + 1 : 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic load_words(input int n_words);
    int gap;
    for (int k = 0; k < n_words; k++) begin
      gap = rand_bits(2);
      @(posedge i_clk);
      i_load_valid <= 1'b1;
      i_load_word  <= rand_bits(32) | 32'h1;           // Never zero
      repeat (gap) begin
        @(posedge i_clk);
        i_load_valid <= 1'b0;
      end
    end
    @(posedge i_clk);
    i_load_valid <= 1'b0;
  endtask

  task automatic clear_memory();
    int n;
    @(posedge i_clk);
    i_clear <= 1'b1;
    @(posedge i_clk);
    i_clear <= 1'b0;
    n = 0;
    @(negedge i_clk);
    while (o_busy) begin
      n++;
      if (n > `PM_DEPTH + 4) begin
        stop_on_timeout("the clear sweep to end");
      end
      @(negedge i_clk);
    end
  endtask

  task automatic wait_fetched(input int n_words);
    int target;
    int n;
    @(posedge i_clk);
    target = n_fetched + n_words;
    n = 0;
    while (n_fetched < target) begin
      @(posedge i_clk);
      n++;
      if (n > 4 * n_words + 32) begin
        stop_on_timeout("fetched instructions");
      end
    end
  endtask

  task automatic check_status(input int count, input logic full, input logic ovw);
    @(negedge i_clk);
    assert (o_load_count == count && o_load_full == full && o_overwrite == ovw)
      else report_error($sformatf("count %0d full %0b overwrite %0b, expected %0d %0b %0b",
                                  o_load_count, o_load_full, o_overwrite, count, full, ovw));
  endtask

  initial begin : stimulus
    i_rsta       = 1'b1;
    i_clear      = 1'b0;
    i_load_start = 1'b0;
    i_load_valid = 1'b0;
    i_load_word  = '0;
    i_run        = 1'b0;
    zero_phase   = 1'b0;
    repeat (2) @(posedge i_clk);
    i_rsta <= 1'b0;

    clear_memory();                                   // Contents are not reset
    @(posedge i_clk);
    i_load_start <= 1'b1;
    @(posedge i_clk);
    i_load_start <= 1'b0;
    load_words(`PM_DEPTH);
    check_status(`PM_DEPTH, 1'b1, 1'b0);

    // Two passes then a stop so the PC restarts at 0
    @(posedge i_clk);
    i_run <= 1'b1;
    wait_fetched(2 * `PM_DEPTH);
    i_run <= 1'b0;
    repeat (3) @(posedge i_clk);
    i_run        <= 1'b1;
    i_load_start <= 1'b1;                             // Reload under a running fetch
    @(posedge i_clk);
    i_load_start <= 1'b0;
    load_words(`PM_DEPTH);
    check_status(`PM_DEPTH, 1'b1, 1'b1);
    wait_fetched(`PM_DEPTH);

    load_words(8);                                    // Past full so all are dropped
    check_status(`PM_DEPTH, 1'b1, 1'b1);
    wait_fetched(`PM_DEPTH);

    clear_memory();                                   // Core still running
    check_status(`PM_DEPTH, 1'b1, 1'b0);
    @(posedge i_clk);
    zero_phase = 1'b1;
    wait_fetched(`PM_DEPTH);
    i_run <= 1'b0;
    repeat (4) @(posedge i_clk);
    if (exp_q.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("%0d fetched words never came back", exp_q.size());
      $display("SIMULATION FAILED");
      $fatal(1, "Missing instruction returns");
    end
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
logic/pm_pkg.sv
logic/program_memory.sv
logic/memory_arbiter.sv
logic/program_loader.sv
logic/instruction_fetch.sv
logic/program_subsystem_top.sv
verif/program_subsystem_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      := program_subsystem_tb
FILELIST := build.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
